//--- list.f
rtl/avr_isa_pkg.sv
rtl/avr_mem_pkg.sv
rtl/avr_decoder.sv
rtl/avr_regfile.sv
rtl/avr_alu.sv
rtl/avr_sequencer.sv
rtl/avr_execute.sv
rtl/avr_cpu.sv
tb/avr_cpu_assertions.sv
tb/avr_cpu_tb.sv

//--- rtl/avr_alu.sv
`default_nettype none

module avr_alu (
	input wire avr_isa_pkg::alu_op_e op,
	input wire logic use_carry,
	input wire avr_isa_pkg::byte_t rd_val,
	input wire avr_isa_pkg::byte_t rr_val,
	input wire avr_isa_pkg::sreg_t sreg_in,
	output avr_isa_pkg::byte_t result,
	output avr_isa_pkg::sreg_t sreg_out
);
	logic c_in;
	logic carry;
	logic [8:0] wide;
	avr_isa_pkg::byte_t res;
	logic f_c;
	logic f_h;
	logic f_v;
	logic upd;

	always_comb begin
		c_in = sreg_in[avr_isa_pkg::SREG_C];
		// carry only feeds ADC and SBC style ops
		carry = use_carry & c_in;
		wide = '0;
		res = rd_val;
		f_c = c_in;
		f_h = sreg_in[avr_isa_pkg::SREG_H];
		f_v = 1'b0;
		upd = 1'b1;

		case (op)
		avr_isa_pkg::ALU_MOVE: upd = 1'b0;
		avr_isa_pkg::ALU_MOVR: begin
			res = rr_val;
			upd = 1'b0;
		end
		avr_isa_pkg::ALU_ADD: begin
			wide = {1'b0, rd_val} + {1'b0, rr_val} + {8'd0, carry};
			res = wide[7:0];
			f_c = wide[8];
			f_h = (rd_val[3] & rr_val[3]) | (rr_val[3] & ~res[3]) | (~res[3] & rd_val[3]);
			f_v = (rd_val[7] & rr_val[7] & ~res[7]) | (~rd_val[7] & ~rr_val[7] & res[7]);
		end
		avr_isa_pkg::ALU_SUB: begin
			// bit 8 of the wrapped difference is the borrow
			wide = {1'b0, rd_val} - {1'b0, rr_val} - {8'd0, carry};
			res = wide[7:0];
			f_c = wide[8];
			f_h = (~rd_val[3] & rr_val[3]) | (rr_val[3] & res[3]) | (res[3] & ~rd_val[3]);
			f_v = (rd_val[7] & ~rr_val[7] & ~res[7]) | (~rd_val[7] & rr_val[7] & res[7]);
		end
		avr_isa_pkg::ALU_AND: res = rd_val & rr_val;
		avr_isa_pkg::ALU_OR: res = rd_val | rr_val;
		avr_isa_pkg::ALU_EOR: res = rd_val ^ rr_val;
		avr_isa_pkg::ALU_NEG: begin
			res = 8'd0 - rd_val;
			f_c = (res != 8'd0);
			f_h = res[3] | rd_val[3];
			f_v = (res == 8'h80);
		end
		avr_isa_pkg::ALU_SWAP: begin
			res = {rd_val[3:0], rd_val[7:4]};
			upd = 1'b0;
		end
		avr_isa_pkg::ALU_LSR: begin
			res = {1'b0, rd_val[7:1]};
			f_c = rd_val[0];
			// N is zero, so V = C
			f_v = rd_val[0];
		end
		avr_isa_pkg::ALU_ASR: begin
			res = {rd_val[7], rd_val[7:1]};
			f_c = rd_val[0];
			f_v = rd_val[7] ^ rd_val[0];
		end
		avr_isa_pkg::ALU_ROR: begin
			res = {c_in, rd_val[7:1]};
			f_c = rd_val[0];
			f_v = c_in ^ rd_val[0];
		end
		default: upd = 1'b0;
		endcase

		sreg_out = sreg_in;
		if (upd) begin
			sreg_out[avr_isa_pkg::SREG_H] = f_h;
			sreg_out[avr_isa_pkg::SREG_V] = f_v;
			sreg_out[avr_isa_pkg::SREG_N] = res[7];
			sreg_out[avr_isa_pkg::SREG_S] = res[7] ^ f_v;
			sreg_out[avr_isa_pkg::SREG_C] = f_c;
			// SBC/CPC chain Z across bytes, the low byte must have been zero too
			if (op == avr_isa_pkg::ALU_SUB && use_carry) begin
				sreg_out[avr_isa_pkg::SREG_Z] = (res == 8'd0) & sreg_in[avr_isa_pkg::SREG_Z];
			end else begin
				sreg_out[avr_isa_pkg::SREG_Z] = (res == 8'd0);
			end
		end
	end

	assign result = res;

endmodule

`default_nettype wire

//--- rtl/avr_cpu.sv
`default_nettype none

module avr_cpu (
	input wire logic clk,
	input wire logic reset,
	input wire avr_isa_pkg::opcode_t cdata,
	input wire avr_isa_pkg::byte_t data_read,
	output avr_mem_pkg::addr_t pc,
	output avr_mem_pkg::dmem_req_t dmem
);
	avr_isa_pkg::opcode_t opcode;
	avr_isa_pkg::step_t step;
	avr_isa_pkg::dec_t dec;
	avr_isa_pkg::byte_t rd_a;
	avr_isa_pkg::byte_t rd_b;
	avr_isa_pkg::reg_sel_t wb_sel;
	avr_isa_pkg::byte_t wb_data;
	logic wb_en;
	// status as it will be after this cycle, so branches see the last compare
	avr_isa_pkg::sreg_t flags_next;

	avr_sequencer u_sequencer (
		.clk(clk),
		.reset(reset),
		.cdata(cdata),
		.dec(dec),
		.rd_a(rd_a),
		.opcode(opcode),
		.step(step),
		.pc(pc),
		.dmem(dmem)
	);

	avr_decoder u_decoder (
		.opcode(opcode),
		.step(step),
		.flags_next(flags_next),
		.dec(dec)
	);

	avr_regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.sel_a(dec.sel_a),
		.sel_b(dec.sel_b),
		.wb_sel(wb_sel),
		.wb_data(wb_data),
		.wb_en(wb_en),
		.rd_a(rd_a),
		.rd_b(rd_b)
	);

	avr_execute u_execute (
		.clk(clk),
		.reset(reset),
		.ex_in(dec.ex),
		.data_read(data_read),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.wb_sel(wb_sel),
		.wb_data(wb_data),
		.wb_en(wb_en),
		.flags_next(flags_next)
	);

endmodule

`default_nettype wire

//--- rtl/avr_decoder.sv
`default_nettype none

module avr_decoder (
	input wire avr_isa_pkg::opcode_t opcode,
	input wire avr_isa_pkg::step_t step,
	input wire avr_isa_pkg::sreg_t flags_next,
	output avr_isa_pkg::dec_t dec
);
	// operand fields
	avr_isa_pkg::reg_sel_t op_rd;
	avr_isa_pkg::reg_sel_t op_rr;
	avr_isa_pkg::reg_sel_t op_rdi;
	avr_isa_pkg::byte_t op_k;

	assign op_rd = opcode[8:4];
	assign op_rr = {opcode[9], opcode[3:0]};
	// immediate forms only reach r16..r31
	assign op_rdi = {1'b1, opcode[7:4]};
	assign op_k = {opcode[11:8], opcode[3:0]};

	always_comb begin
		// default is a nop that just advances
		dec = '0;
		dec.sel_a = op_rd;
		dec.sel_b = op_rr;
		dec.ex.alu_op = avr_isa_pkg::ALU_MOVE;
		dec.ex.dest = op_rd;
		dec.pc_act = avr_isa_pkg::PC_NEXT;

		casez (opcode)
		// two register ops
		16'b000?_????_????_????, 16'b0010_????_????_????: begin
			case (opcode[13:10])
			4'b0001: begin
				// CPC, flags only
				dec.ex.alu_op = avr_isa_pkg::ALU_SUB;
				dec.ex.use_carry = 1'b1;
			end
			4'b0010: begin
				dec.ex.alu_op = avr_isa_pkg::ALU_SUB;
				dec.ex.use_carry = 1'b1;
				dec.ex.store = 1'b1;
			end
			4'b0011: begin
				dec.ex.alu_op = avr_isa_pkg::ALU_ADD;
				dec.ex.store = 1'b1;
			end
			// CP
			4'b0101: dec.ex.alu_op = avr_isa_pkg::ALU_SUB;
			4'b0110: begin
				dec.ex.alu_op = avr_isa_pkg::ALU_SUB;
				dec.ex.store = 1'b1;
			end
			4'b0111: begin
				dec.ex.alu_op = avr_isa_pkg::ALU_ADD;
				dec.ex.use_carry = 1'b1;
				dec.ex.store = 1'b1;
			end
			4'b1000: begin
				dec.ex.alu_op = avr_isa_pkg::ALU_AND;
				dec.ex.store = 1'b1;
			end
			4'b1001: begin
				dec.ex.alu_op = avr_isa_pkg::ALU_EOR;
				dec.ex.store = 1'b1;
			end
			4'b1010: begin
				dec.ex.alu_op = avr_isa_pkg::ALU_OR;
				dec.ex.store = 1'b1;
			end
			4'b1011: begin
				dec.ex.alu_op = avr_isa_pkg::ALU_MOVR;
				dec.ex.store = 1'b1;
			end
			// nop, movw and cpse fall through as nop
			default: dec.ex.store = 1'b0;
			endcase
		end
		// CPI, SBCI, SUBI, ORI, ANDI
		16'b0011_????_????_????, 16'b01??_????_????_????: begin
			dec.sel_a = op_rdi;
			dec.ex.dest = op_rdi;
			dec.ex.use_const = 1'b1;
			dec.ex.const_val = op_k;
			dec.ex.store = 1'b1;
			case (opcode[14:12])
			3'b011: begin
				dec.ex.alu_op = avr_isa_pkg::ALU_SUB;
				dec.ex.store = 1'b0;
			end
			3'b100: begin
				dec.ex.alu_op = avr_isa_pkg::ALU_SUB;
				dec.ex.use_carry = 1'b1;
			end
			3'b101: dec.ex.alu_op = avr_isa_pkg::ALU_SUB;
			3'b110: dec.ex.alu_op = avr_isa_pkg::ALU_OR;
			default: dec.ex.alu_op = avr_isa_pkg::ALU_AND;
			endcase
		end
		16'b1110_????_????_????: begin
			// LDI, no flags
			dec.ex.dest = op_rdi;
			dec.ex.alu_op = avr_isa_pkg::ALU_MOVR;
			dec.ex.use_const = 1'b1;
			dec.ex.const_val = op_k;
			dec.ex.store = 1'b1;
		end
		// single register ops
		16'b1001_010?_????_0???, 16'b1001_010?_????_1010: begin
			dec.ex.store = 1'b1;
			case (opcode[3:0])
			4'b0000: begin
				// COM is rd ^ 0xff
				dec.ex.alu_op = avr_isa_pkg::ALU_EOR;
				dec.ex.use_const = 1'b1;
				dec.ex.const_val = 8'hff;
			end
			4'b0001: dec.ex.alu_op = avr_isa_pkg::ALU_NEG;
			4'b0010: dec.ex.alu_op = avr_isa_pkg::ALU_SWAP;
			4'b0011: begin
				dec.ex.alu_op = avr_isa_pkg::ALU_ADD;
				dec.ex.use_const = 1'b1;
				dec.ex.const_val = 8'd1;
			end
			4'b0101: dec.ex.alu_op = avr_isa_pkg::ALU_ASR;
			4'b0110: dec.ex.alu_op = avr_isa_pkg::ALU_LSR;
			4'b0111: dec.ex.alu_op = avr_isa_pkg::ALU_ROR;
			4'b1010: begin
				dec.ex.alu_op = avr_isa_pkg::ALU_SUB;
				dec.ex.use_const = 1'b1;
				dec.ex.const_val = 8'd1;
			end
			default: dec.ex.store = 1'b0;
			endcase
		end
		// LDS and STS, address in the following word
		16'b1001_00??_????_0000: begin
			case (step)
			// rd read starts here, pc moves on to the address word
			2'd0: dec.next_step = 2'd1;
			2'd1: begin
				if (opcode[9]) begin
					dec.mem_wen = 1'b1;
				end else begin
					dec.mem_ren = 1'b1;
					dec.next_step = 2'd2;
				end
			end
			2'd2: begin
				// next opcode is already addressed, keep it there
				dec.pc_act = avr_isa_pkg::PC_HOLD;
				dec.ex.alu_op = avr_isa_pkg::ALU_MOVR;
				dec.ex.use_const = 1'b1;
				dec.ex.from_mem = 1'b1;
				dec.ex.store = 1'b1;
			end
			default: dec.next_step = 2'd0;
			endcase
		end
		16'b1100_????_????_????: begin
			dec.pc_act = avr_isa_pkg::PC_REL;
			dec.pc_off = opcode[11:0];
		end
		// BRBS when bit 10 is clear, BRBC when set
		16'b1111_0???_????_????: begin
			if (flags_next[opcode[2:0]] != opcode[10]) begin
				dec.pc_act = avr_isa_pkg::PC_REL;
				dec.pc_off = {{5{opcode[9]}}, opcode[9:3]};
			end
		end
		default: dec.ex.store = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/avr_execute.sv
`default_nettype none

module avr_execute (
	input wire logic clk,
	input wire logic reset,
	input wire avr_isa_pkg::ex_ctrl_t ex_in,
	input wire avr_isa_pkg::byte_t data_read,
	input wire avr_isa_pkg::byte_t rd_a,
	input wire avr_isa_pkg::byte_t rd_b,
	output avr_isa_pkg::reg_sel_t wb_sel,
	output avr_isa_pkg::byte_t wb_data,
	output logic wb_en,
	output avr_isa_pkg::sreg_t flags_next
);
	avr_isa_pkg::ex_ctrl_t ex_q;
	avr_isa_pkg::byte_t const_q;
	avr_isa_pkg::sreg_t sreg_q;
	avr_isa_pkg::byte_t operand_b;

	// command lines up with the register reads issued in the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_q <= '0;
			sreg_q <= '0;
		end else begin
			ex_q <= ex_in;
			sreg_q <= flags_next;
		end
	end

	// LDS result is on data_read in the cycle that decodes step 2
	always_ff @(posedge clk) begin
		const_q <= ex_in.from_mem ? data_read : ex_in.const_val;
	end

	assign operand_b = ex_q.use_const ? const_q : rd_b;

	avr_alu u_alu (
		.op(ex_q.alu_op),
		.use_carry(ex_q.use_carry),
		.rd_val(rd_a),
		.rr_val(operand_b),
		.sreg_in(sreg_q),
		.result(wb_data),
		.sreg_out(flags_next)
	);

	// write lands at the end of this cycle, forwarded by the register file
	assign wb_sel = ex_q.dest;
	assign wb_en = ex_q.store;

endmodule

`default_nettype wire

//--- rtl/avr_isa_pkg.sv
`default_nettype none

package avr_isa_pkg;

	// register file depth
	localparam int NUM_REGS = 32;

	// status register bit positions
	localparam int SREG_C = 0;
	localparam int SREG_Z = 1;
	localparam int SREG_N = 2;
	localparam int SREG_V = 3;
	localparam int SREG_S = 4;
	localparam int SREG_H = 5;

	typedef logic [15:0] opcode_t;
	typedef logic [4:0] reg_sel_t;
	typedef logic [7:0] byte_t;
	typedef logic [7:0] sreg_t;
	typedef logic [1:0] step_t;
	// relative jump distance in words
	typedef logic signed [11:0] pc_off_t;

	// move ops leave the flags alone
	typedef enum logic [3:0] {
		ALU_MOVE, ALU_MOVR, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
		ALU_EOR, ALU_NEG, ALU_SWAP, ALU_LSR, ALU_ASR, ALU_ROR
	} alu_op_e;

	typedef enum logic [1:0] {
		PC_NEXT, PC_HOLD, PC_REL
	} pc_act_e;

	// command handed from decode to execute
	typedef struct packed {
		alu_op_e alu_op;
		reg_sel_t dest;
		logic store;
		logic use_carry;
		logic use_const;
		byte_t const_val;
		// constant comes from data_read instead of const_val
		logic from_mem;
	} ex_ctrl_t;

	typedef struct packed {
		reg_sel_t sel_a;
		reg_sel_t sel_b;
		ex_ctrl_t ex;
		pc_act_e pc_act;
		pc_off_t pc_off;
		step_t next_step;
		logic mem_wen;
		logic mem_ren;
	} dec_t;

endpackage

`default_nettype wire

//--- rtl/avr_mem_pkg.sv
`default_nettype none

package avr_mem_pkg;

	// program word address or data byte address
	typedef logic [15:0] addr_t;

	// data bus request, driven straight from decode
	typedef struct packed {
		addr_t addr;
		logic wen;
		logic ren;
		avr_isa_pkg::byte_t wdata;
	} dmem_req_t;

endpackage

`default_nettype wire

//--- rtl/avr_regfile.sv
`default_nettype none

module avr_regfile (
	input wire logic clk,
	input wire logic reset,
	input wire avr_isa_pkg::reg_sel_t sel_a,
	input wire avr_isa_pkg::reg_sel_t sel_b,
	input wire avr_isa_pkg::reg_sel_t wb_sel,
	input wire avr_isa_pkg::byte_t wb_data,
	input wire logic wb_en,
	output avr_isa_pkg::byte_t rd_a,
	output avr_isa_pkg::byte_t rd_b
);
	// r0..r31 as flops
	avr_isa_pkg::byte_t regs [avr_isa_pkg::NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < avr_isa_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_sel] <= wb_data;
		end
	end

	// reads land in the next cycle
	// a write to the same register in this cycle is passed through
	always_ff @(posedge clk) begin
		if (wb_en && wb_sel == sel_a) begin
			rd_a <= wb_data;
		end else begin
			rd_a <= regs[sel_a];
		end

		if (wb_en && wb_sel == sel_b) begin
			rd_b <= wb_data;
		end else begin
			rd_b <= regs[sel_b];
		end
	end

endmodule

`default_nettype wire

//--- rtl/avr_sequencer.sv
`default_nettype none

module avr_sequencer (
	input wire logic clk,
	input wire logic reset,
	input wire avr_isa_pkg::opcode_t cdata,
	input wire avr_isa_pkg::dec_t dec,
	input wire avr_isa_pkg::byte_t rd_a,
	output avr_isa_pkg::opcode_t opcode,
	output avr_isa_pkg::step_t step,
	output avr_mem_pkg::addr_t pc,
	output avr_mem_pkg::dmem_req_t dmem
);
	// word address of whatever is on cdata right now
	avr_mem_pkg::addr_t pc_q;
	avr_isa_pkg::step_t step_q;
	// first word of a multi-cycle instruction
	avr_isa_pkg::opcode_t held_q;
	avr_mem_pkg::addr_t off_ext;

	assign step = step_q;
	// later steps see the address word on cdata, so decode the held opcode
	assign opcode = (step_q == 2'd0) ? cdata : held_q;

	always_comb begin
		off_ext = {{4{dec.pc_off[11]}}, dec.pc_off};
		if (reset) begin
			pc = '0;
		end else begin
			case (dec.pc_act)
			avr_isa_pkg::PC_HOLD: pc = pc_q;
			// relative targets count from the word after the jump
			avr_isa_pkg::PC_REL: pc = pc_q + off_ext + 16'd1;
			default: pc = pc_q + 16'd1;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q <= '0;
			step_q <= '0;
		end else begin
			pc_q <= pc;
			step_q <= dec.next_step;
		end
	end

	always_ff @(posedge clk) begin
		held_q <= opcode;
	end

	// address word sits on cdata during the LDS/STS access step
	// store data is the rd read set up in step 0
	always_comb begin
		dmem.wen = dec.mem_wen;
		dmem.ren = dec.mem_ren;
		if (dec.mem_wen || dec.mem_ren) begin
			dmem.addr = cdata;
		end else begin
			dmem.addr = '0;
		end
		if (dec.mem_wen) begin
			dmem.wdata = rd_a;
		end else begin
			dmem.wdata = '0;
		end
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module avr_cpu_tb \
	-Mdir obj_dir -o avr_cpu_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/avr_cpu_sim > sim.log 2>&1 || echo "simulator exited with an error"
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

//--- tb/avr_cpu_assertions.sv
`default_nettype none

module avr_cpu_assertions (
	input wire logic clk,
	input wire logic reset,
	input wire avr_mem_pkg::addr_t pc,
	input wire avr_mem_pkg::dmem_req_t dmem,
	input wire avr_isa_pkg::pc_act_e pc_act
);

	// one data access per cycle at most
	a_single_access: assert property (@(posedge clk) !(dmem.wen && dmem.ren))
		else $error("data bus read and write strobes high in the same cycle");

	// bus stays quiet while the core is held in reset
	a_quiet_in_reset: assert property (@(posedge clk) reset |-> !(dmem.wen || dmem.ren))
		else $error("data bus strobe high during reset");

	// pc only stands still on a hold step
	a_pc_moves: assert property (@(posedge clk) disable iff (reset)
		pc_act != avr_isa_pkg::PC_HOLD |-> pc != $past(pc))
		else $error("pc did not move on a cycle without a hold");

endmodule

bind avr_cpu avr_cpu_assertions u_assertions (
	.clk(clk),
	.reset(reset),
	.pc(pc),
	.dmem(dmem),
	.pc_act(dec.pc_act)
);

`default_nettype wire

//--- tb/avr_cpu_tb.sv
`default_nettype none

module avr_cpu_tb;

	localparam int MAX_TESTS = 32;
	localparam int PROG_WORDS = 12;
	localparam int TIMEOUT_CYCLES = 200;
	localparam logic [15:0] RES_ADDR = 16'h0040;
	localparam logic [15:0] SCRATCH_ADDR = 16'h0030;
	// a store here ends a program
	localparam logic [15:0] DONE_ADDR = 16'h00ff;

	logic clk = 1'b0;
	logic reset = 1'b1;
	avr_isa_pkg::opcode_t cdata = '0;
	avr_isa_pkg::byte_t data_read = '0;
	avr_mem_pkg::addr_t pc;
	avr_mem_pkg::dmem_req_t dmem;

	avr_isa_pkg::opcode_t rom [256];
	avr_isa_pkg::byte_t ram [256];
	int done_count = 0;

	// test table, one row per program
	string test_name [MAX_TESTS];
	avr_isa_pkg::opcode_t test_prog [MAX_TESTS][PROG_WORDS];
	avr_mem_pkg::addr_t test_addr [MAX_TESTS];
	logic [15:0] test_exp [MAX_TESTS];
	int test_bytes [MAX_TESTS];
	int num_tests = 0;

	// program being assembled
	avr_isa_pkg::opcode_t words [PROG_WORDS];
	int num_words = 0;
	logic [31:0] lfsr = 32'h38d6_9c18;
	int pass_count = 0;
	int fail_count = 0;

	avr_cpu u_avr_cpu (
		.clk(clk),
		.reset(reset),
		.cdata(cdata),
		.data_read(data_read),
		.pc(pc),
		.dmem(dmem)
	);

	always #10 clk = ~clk;

	// program memory, word at pc one cycle later
	always @(posedge clk) begin
		cdata <= rom[pc[7:0]];
	end

	// data memory, refilled while the core sits in reset
	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 256; i++) begin
				ram[i] <= 8'(i) ^ 8'h3c;
			end
		end else begin
			if (dmem.wen) begin
				ram[dmem.addr[7:0]] <= dmem.wdata;
			end
			if (dmem.ren) begin
				data_read <= ram[dmem.addr[7:0]];
			end
			if (dmem.wen && dmem.addr == DONE_ADDR) begin
				done_count <= done_count + 1;
			end
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	// LDI, CPI, SUBI, SBCI, ORI, ANDI share one layout, rd is r16..r31
	function automatic avr_isa_pkg::opcode_t imm_word(input logic [3:0] op,
			input avr_isa_pkg::reg_sel_t d, input avr_isa_pkg::byte_t k);
		return {op, k[7:4], d[3:0], k[3:0]};
	endfunction

	function automatic avr_isa_pkg::opcode_t reg_word(input logic [5:0] op,
			input avr_isa_pkg::reg_sel_t d, input avr_isa_pkg::reg_sel_t r);
		return {op, r[4], d, r[3:0]};
	endfunction

	function automatic avr_isa_pkg::opcode_t single_word(input avr_isa_pkg::reg_sel_t d,
			input logic [3:0] fn);
		return {7'b1001_010, d, fn};
	endfunction

	function automatic avr_isa_pkg::opcode_t rjmp_word(input logic [11:0] k);
		return {4'hc, k};
	endfunction

	// clr picks BRBC over BRBS
	function automatic avr_isa_pkg::opcode_t branch_word(input logic clr, input logic [2:0] s,
			input logic [6:0] k);
		return {5'b11110, clr, k, s};
	endfunction

	task automatic new_program();
		num_words = 0;
		for (int i = 0; i < PROG_WORDS; i++) begin
			words[i] = '0;
		end
	endtask

	task automatic append_word(input avr_isa_pkg::opcode_t w);
		words[num_words] = w;
		num_words++;
	endtask

	// STS is the opcode then the address word
	task automatic store_to(input avr_mem_pkg::addr_t a, input avr_isa_pkg::reg_sel_t r);
		append_word({7'b1001_001, r, 4'h0});
		append_word(a);
	endtask

	task automatic load_from(input avr_isa_pkg::reg_sel_t d, input avr_mem_pkg::addr_t a);
		append_word({7'b1001_000, d, 4'h0});
		append_word(a);
	endtask

	task automatic add_row(input string name, input logic [15:0] exp, input int nbytes);
		test_name[num_tests] = name;
		for (int i = 0; i < PROG_WORDS; i++) begin
			test_prog[num_tests][i] = words[i];
		end
		test_addr[num_tests] = RES_ADDR;
		test_exp[num_tests] = exp;
		test_bytes[num_tests] = nbytes;
		num_tests++;
	endtask

	task automatic ldi_case(input string name, input avr_isa_pkg::reg_sel_t d,
			input avr_isa_pkg::byte_t k);
		new_program();
		append_word(imm_word(4'he, d, k));
		store_to(RES_ADDR, d);
		store_to(DONE_ADDR, d);
		add_row(name, {8'h00, k}, 1);
	endtask

	// second LDI lands right before the op, so r17 comes through forwarding
	task automatic reg_op_case(input string name, input logic [5:0] op,
			input avr_isa_pkg::byte_t a, input avr_isa_pkg::byte_t b,
			input avr_isa_pkg::byte_t exp);
		new_program();
		append_word(imm_word(4'he, 5'd16, a));
		append_word(imm_word(4'he, 5'd17, b));
		append_word(reg_word(op, 5'd16, 5'd17));
		store_to(RES_ADDR, 5'd16);
		store_to(DONE_ADDR, 5'd16);
		add_row(name, {8'h00, exp}, 1);
	endtask

	task automatic imm_op_case(input string name, input logic [3:0] op,
			input avr_isa_pkg::byte_t a, input avr_isa_pkg::byte_t k,
			input avr_isa_pkg::byte_t exp);
		new_program();
		append_word(imm_word(4'he, 5'd20, a));
		append_word(imm_word(op, 5'd20, k));
		store_to(RES_ADDR, 5'd20);
		store_to(DONE_ADDR, 5'd20);
		add_row(name, {8'h00, exp}, 1);
	endtask

	task automatic single_op_case(input string name, input logic [3:0] fn,
			input avr_isa_pkg::byte_t a, input avr_isa_pkg::byte_t exp);
		new_program();
		append_word(imm_word(4'he, 5'd20, a));
		append_word(single_word(5'd20, fn));
		store_to(RES_ADDR, 5'd20);
		store_to(DONE_ADDR, 5'd20);
		add_row(name, {8'h00, exp}, 1);
	endtask

	// x in r17:r16, y in r19:r18, result low byte first
	task automatic carry_case(input string name, input logic [5:0] lo_op,
			input logic [5:0] hi_op, input logic [15:0] x, input logic [15:0] y,
			input logic [15:0] exp);
		new_program();
		append_word(imm_word(4'he, 5'd16, x[7:0]));
		append_word(imm_word(4'he, 5'd17, x[15:8]));
		append_word(imm_word(4'he, 5'd18, y[7:0]));
		append_word(imm_word(4'he, 5'd19, y[15:8]));
		append_word(reg_word(lo_op, 5'd16, 5'd18));
		append_word(reg_word(hi_op, 5'd17, 5'd19));
		store_to(RES_ADDR, 5'd16);
		store_to(RES_ADDR + 16'd1, 5'd17);
		store_to(DONE_ADDR, 5'd17);
		add_row(name, exp, 2);
	endtask

	// CPI then branch to word 8, fall-through path jumps from word 7 to word 10
	task automatic branch_case(input string name, input logic clr, input logic [2:0] s,
			input avr_isa_pkg::byte_t a, input avr_isa_pkg::byte_t k);
		logic flag;
		logic taken;
		// Z is equality, C is an unsigned borrow
		if (s == 3'd1) begin
			flag = (a == k);
		end else begin
			flag = (a < k);
		end
		taken = flag ^ clr;
		new_program();
		append_word(imm_word(4'he, 5'd16, a));
		append_word(imm_word(4'he, 5'd17, 8'h11));
		append_word(imm_word(4'he, 5'd18, 8'h22));
		append_word(imm_word(4'h3, 5'd16, k));
		append_word(branch_word(clr, s, 7'd3));
		store_to(RES_ADDR, 5'd18);
		append_word(rjmp_word(12'd2));
		store_to(RES_ADDR, 5'd17);
		store_to(DONE_ADDR, 5'd16);
		add_row(name, taken ? 16'h0011 : 16'h0022, 1);
	endtask

	task automatic lds_case(input string name, input avr_isa_pkg::byte_t v);
		new_program();
		append_word(imm_word(4'he, 5'd16, v));
		store_to(SCRATCH_ADDR, 5'd16);
		load_from(5'd5, SCRATCH_ADDR);
		store_to(RES_ADDR, 5'd5);
		store_to(DONE_ADDR, 5'd5);
		add_row(name, {8'h00, v}, 1);
	endtask

	task automatic build_table();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] k;
		logic [7:0] r;
		logic [15:0] x;
		logic [15:0] y;
		rand_bits(4, r);
		rand_bits(8, k);
		ldi_case("ldi", {1'b1, r[3:0]}, k);
		rand_bits(8, a);
		rand_bits(8, b);
		reg_op_case("add", 6'b000011, a, b, a + b);
		reg_op_case("sub", 6'b000110, a, b, a - b);
		reg_op_case("and", 6'b001000, a, b, a & b);
		reg_op_case("or", 6'b001010, a, b, a | b);
		reg_op_case("eor", 6'b001001, a, b, a ^ b);
		reg_op_case("mov", 6'b001011, a, b, b);
		rand_bits(8, a);
		rand_bits(8, k);
		imm_op_case("subi", 4'h5, a, k, a - k);
		imm_op_case("andi", 4'h7, a, k, a & k);
		imm_op_case("ori", 4'h6, a, k, a | k);
		single_op_case("inc", 4'h3, a, a + 8'd1);
		single_op_case("dec", 4'ha, a, a - 8'd1);
		single_op_case("com", 4'h0, a, ~a);
		single_op_case("neg", 4'h1, a, 8'd0 - a);
		single_op_case("swap", 4'h2, a, {a[3:0], a[7:4]});
		single_op_case("lsr", 4'h6, a, {1'b0, a[7:1]});
		single_op_case("asr", 4'h5, a, {a[7], a[7:1]});
		// 0 minus 1 borrows, so C is set going into ROR
		new_program();
		append_word(imm_word(4'he, 5'd20, a));
		append_word(imm_word(4'he, 5'd21, 8'h00));
		append_word(imm_word(4'h3, 5'd21, 8'h01));
		append_word(single_word(5'd20, 4'h7));
		store_to(RES_ADDR, 5'd20);
		store_to(DONE_ADDR, 5'd20);
		add_row("ror", {8'h00, 1'b1, a[7:1]}, 1);
		rand_bits(8, x[7:0]);
		rand_bits(8, x[15:8]);
		rand_bits(8, y[7:0]);
		rand_bits(8, y[15:8]);
		// both low bytes at 0x80 or above, so the low add carries
		x[7] = 1'b1;
		y[7] = 1'b1;
		carry_case("add16", 6'b000011, 6'b000111, x, y, x + y);
		// low byte of x below 0x80 and of y above, so the low subtract borrows
		x[7] = 1'b0;
		carry_case("sub16", 6'b000110, 6'b000010, x, y, x - y);
		branch_case("brbs z eq", 1'b0, 3'd1, a, a);
		branch_case("brbs z ne", 1'b0, 3'd1, a, a ^ 8'h01);
		branch_case("brbc z eq", 1'b1, 3'd1, a, a);
		branch_case("brbs c", 1'b0, 3'd0, a, k);
		branch_case("brbc c", 1'b1, 3'd0, a, k);
		rand_bits(8, b);
		lds_case("lds", b);
	endtask

	task automatic run_row(input int t);
		int start;
		int cycles;
		logic [7:0] a;
		logic [15:0] got;
		logic ok;
		@(posedge clk);
		reset <= 1'b1;
		for (int i = 0; i < 256; i++) begin
			rom[i] = '0;
		end
		for (int i = 0; i < PROG_WORDS; i++) begin
			rom[i] = test_prog[t][i];
		end
		repeat (8) @(posedge clk);
		start = done_count;
		reset <= 1'b0;
		cycles = 0;
		while (done_count == start && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		ok = 1'b1;
		if (done_count == start) begin
			$display("%s: the program did not reach its final store within %0d cycles",
				test_name[t], TIMEOUT_CYCLES);
			ok = 1'b0;
		end else begin
			a = test_addr[t][7:0];
			got = (test_bytes[t] == 2) ? {ram[a + 8'd1], ram[a]} : {8'h00, ram[a]};
			assert (got == test_exp[t]) else begin
				$display("** Error %s: expected %h, actual %h", test_name[t], test_exp[t], got);
				ok = 1'b0;
			end
		end
		if (ok) begin
			pass_count++;
		end else begin
			fail_count++;
		end
		$display("%s: %s", test_name[t], ok ? "pass" : "FAIL");
	endtask

	initial begin
		build_table();
		for (int t = 0; t < num_tests; t++) begin
			run_row(t);
		end
		$display("%0d tests, %0d passed, %0d failed", num_tests, pass_count, fail_count);
		if (fail_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
